//--- include/status_led_settings.svh
`ifndef STATUS_LED_SETTINGS_SVH
`define STATUS_LED_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Device count
////////////////////////////////////////////////////////////////////////////

// One LED per link device
`define STATUS_NUM_DEVICES 4

////////////////////////////////////////////////////////////////////////////
// Animation timing
////////////////////////////////////////////////////////////////////////////

// Period counter width, 4096 cycles per animation period
`define STATUS_PERIOD_BITS 12

// Brief pulse length in cycles, starting at half period
`define STATUS_PULSE_CYCLES 320

// Period counter bit that toggles the activity blink
`define STATUS_BLINK_BIT 8

// PWM resolution, one PWM window is 2**bits cycles
`define STATUS_PWM_BITS 4

////////////////////////////////////////////////////////////////////////////
// Activity and period counting
////////////////////////////////////////////////////////////////////////////

// Cycles activity stays up after the last strobe
`define STATUS_ACT_TIMEOUT 200
`define STATUS_ACT_TIMEOUT_BITS 8

// Completed-period counter, wraps
`define STATUS_PERIOD_COUNT_BITS 16

`endif

//--- source/status_led_pkg.sv
package status_led_pkg;

	// APB bus shape
	typedef logic [3:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

	////////////////////////////////////////////////////////////////////////
	// LED animation modes
	////////////////////////////////////////////////////////////////////////

	// Listed in priority order, highest first
	typedef enum logic [1:0]
	{
		MODE_ERROR  = 2'd0,
		MODE_ACTIVE = 2'd1,
		MODE_IDLE   = 2'd2,
		MODE_OFF    = 2'd3
	} led_mode_t;

	////////////////////////////////////////////////////////////////////////
	// APB register map (byte offsets)
	////////////////////////////////////////////////////////////////////////

	// Writable masks
	localparam apb_addr_t REG_ERROR     = 4'h0;
	localparam apb_addr_t REG_CONNECTED = 4'h4;
	// Read only
	localparam apb_addr_t REG_ACTIVITY  = 4'h8;
	localparam apb_addr_t REG_PERIODS   = 4'hC;

endpackage

//--- source/status_apb_regs.sv
`include "status_led_settings.svh"

module status_apb_regs
	import status_led_pkg::*;
(
	input  logic                            CLK_IN,
	input  logic                            RESET_IN,
	// APB slave side
	input  logic                            psel_i,
	input  logic                            penable_i,
	input  logic                            pwrite_i,
	input  apb_addr_t                       paddr_i,
	input  apb_data_t                       pwdata_i,
	// Status from the LED logic
	input  logic [`STATUS_NUM_DEVICES-1:0] activity_status_i,
	input  logic                            period_end_i,
	// APB responses
	output apb_data_t                       prdata_o,
	output logic                            pready_o,
	output logic                            pslverr_o,
	// Software masks, one bit per device
	output logic [`STATUS_NUM_DEVICES-1:0] error_mask_o,
	output logic [`STATUS_NUM_DEVICES-1:0] connected_mask_o
);

	// Wrapping count of completed animation periods
	logic [`STATUS_PERIOD_COUNT_BITS-1:0] period_count;

	// Decode results for the current address
	apb_data_t read_data;
	logic      read_ok;
	logic      write_ok;
	logic      bad_access;

	// Bus phases
	logic setup_phase;
	logic access_write;

	// Slave never stalls
	assign pready_o = 1'b1;

	assign setup_phase  = psel_i && !penable_i;
	assign access_write = psel_i && penable_i && pwrite_i && write_ok;

	////////////////////////////////////////////////////////////////////////
	// Address decode
	////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		read_data = '0;
		read_ok   = 1'b1;
		write_ok  = 1'b0;
		case (paddr_i)
			REG_ERROR:
			begin
				read_data[`STATUS_NUM_DEVICES-1:0] = error_mask_o;
				write_ok = 1'b1;
			end
			REG_CONNECTED:
			begin
				read_data[`STATUS_NUM_DEVICES-1:0] = connected_mask_o;
				write_ok = 1'b1;
			end
			// Status and count are read only
			REG_ACTIVITY:
				read_data[`STATUS_NUM_DEVICES-1:0] = activity_status_i;
			REG_PERIODS:
				read_data[`STATUS_PERIOD_COUNT_BITS-1:0] = period_count;
			default:
				read_ok = 1'b0;
		endcase
		// Unmapped offsets, or writes to read-only registers
		bad_access = pwrite_i ? !write_ok : !read_ok;
	end

	////////////////////////////////////////////////////////////////////////
	// Registers
	////////////////////////////////////////////////////////////////////////

	// Mask writes land at the access-phase edge
	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
		begin
			error_mask_o     <= '0;
			connected_mask_o <= '0;
		end
		else if (access_write)
		begin
			if (paddr_i == REG_ERROR)
				error_mask_o <= pwdata_i[`STATUS_NUM_DEVICES-1:0];
			else
				connected_mask_o <= pwdata_i[`STATUS_NUM_DEVICES-1:0];
		end
	end

	// Read data and error captured in setup, valid through access
	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
		begin
			prdata_o  <= '0;
			pslverr_o <= 1'b0;
		end
		else
		begin
			if (setup_phase && !pwrite_i)
				prdata_o <= read_data;
			// Error only lasts for the access phase
			pslverr_o <= setup_phase && bad_access;
		end
	end

	// One count per period strobe, wraps at full scale
	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
			period_count <= '0;
		else if (period_end_i)
			period_count <= period_count + 1'b1;
	end

endmodule

//--- source/led_animation_timer.sv
`include "status_led_settings.svh"

module led_animation_timer
(
	input  logic                        CLK_IN,
	input  logic                        RESET_IN,
	// Free-running PWM window position
	output logic [`STATUS_PWM_BITS-1:0] pwm_count_o,
	// Brightness levels for each animation
	output logic [`STATUS_PWM_BITS-1:0] pulse_level_o,
	output logic [`STATUS_PWM_BITS-1:0] blink_level_o,
	output logic [`STATUS_PWM_BITS-1:0] throb_level_o,
	// One-cycle strobe per completed period
	output logic                        period_end_o
);

	localparam int PB  = `STATUS_PERIOD_BITS;
	localparam int PWM = `STATUS_PWM_BITS;

	// Pulse window sits at the middle of the period
	localparam logic [PB-1:0] HALF_PERIOD = {1'b1, {(PB-1){1'b0}}};
	localparam logic [PB-1:0] PULSE_LEN   = PB'(`STATUS_PULSE_CYCLES);

	// Position within the animation period
	logic [PB-1:0] period_cnt;

	// Distance past the half-period point, wraps modulo the period
	logic [PB-1:0] pulse_offset;

	// Ramp from the bits just below the MSB
	logic [PWM-1:0] throb_ramp;

	assign pulse_offset = period_cnt - HALF_PERIOD;
	assign throb_ramp   = period_cnt[PB-2 -: PWM];

	////////////////////////////////////////////////////////////////////////
	// Counters
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
		begin
			period_cnt  <= '0;
			pwm_count_o <= '0;
		end
		else
		begin
			period_cnt  <= period_cnt + 1'b1;
			pwm_count_o <= pwm_count_o + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Animation levels, one cycle behind the counter
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
		begin
			period_end_o  <= 1'b0;
			pulse_level_o <= '0;
			blink_level_o <= '0;
			throb_level_o <= '0;
		end
		else
		begin
			// Last position of the period, so the first strobe comes a full period after reset
			period_end_o  <= (period_cnt == '1);
			// Full on inside the pulse window
			pulse_level_o <= {PWM{pulse_offset < PULSE_LEN}};
			// Square wave from one counter bit
			blink_level_o <= {PWM{period_cnt[`STATUS_BLINK_BIT]}};
			// Fade up, then mirror down (inverting is max minus ramp)
			throb_level_o <= period_cnt[PB-1] ? ~throb_ramp : throb_ramp;
		end
	end

endmodule

//--- source/activity_timeout.sv
`include "status_led_settings.svh"

module activity_timeout
(
	input  logic                            CLK_IN,
	input  logic                            RESET_IN,
	// Activity strobes, one per device
	input  logic [`STATUS_NUM_DEVICES-1:0] activity_i,
	// High while the device has been active recently
	output logic [`STATUS_NUM_DEVICES-1:0] activity_status_o
);

	localparam logic [`STATUS_ACT_TIMEOUT_BITS-1:0] TIMEOUT_LOAD =
		`STATUS_ACT_TIMEOUT_BITS'(`STATUS_ACT_TIMEOUT);

	genvar i;

	////////////////////////////////////////////////////////////////////////
	// Retriggerable countdown per device
	////////////////////////////////////////////////////////////////////////

	generate
		for (i = 0; i < `STATUS_NUM_DEVICES; i++)
		begin : dev_timeout
			logic [`STATUS_ACT_TIMEOUT_BITS-1:0] remaining;

			// Each strobe restarts the window
			always_ff @(posedge CLK_IN or posedge RESET_IN)
			begin
				if (RESET_IN)
					remaining <= '0;
				else if (activity_i[i])
					remaining <= TIMEOUT_LOAD;
				else if (remaining != '0)
					remaining <= remaining - 1'b1;
			end

			assign activity_status_o[i] = (remaining != '0);
		end
	endgenerate

endmodule

//--- source/led_pwm_channel.sv
`include "status_led_settings.svh"

module led_pwm_channel
	import status_led_pkg::*;
(
	input  logic                        CLK_IN,
	input  logic                        RESET_IN,
	// Device status bits
	input  logic                        error_i,
	input  logic                        connected_i,
	input  logic                        active_i,
	// Shared timing from the animation timer
	input  logic [`STATUS_PWM_BITS-1:0] pwm_count_i,
	input  logic [`STATUS_PWM_BITS-1:0] pulse_level_i,
	input  logic [`STATUS_PWM_BITS-1:0] blink_level_i,
	input  logic [`STATUS_PWM_BITS-1:0] throb_level_i,
	// LED drive
	output logic                        led_o
);

	led_mode_t mode;

	// Chosen duty, full scale lights 15 of 16 cycles
	logic [`STATUS_PWM_BITS-1:0] pwm_value;

	// Error wins, then activity, then idle
	always_comb
	begin
		if (error_i)
			mode = MODE_ERROR;
		else if (connected_i && active_i)
			mode = MODE_ACTIVE;
		else if (connected_i)
			mode = MODE_IDLE;
		else
			mode = MODE_OFF;
	end

	////////////////////////////////////////////////////////////////////////
	// Duty select and comparator
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
		begin
			pwm_value <= '0;
			led_o     <= 1'b0;
		end
		else
		begin
			case (mode)
				// Lit with a dark pulse mid-period
				MODE_ERROR:  pwm_value <= ~pulse_level_i;
				MODE_ACTIVE: pwm_value <= blink_level_i;
				MODE_IDLE:   pwm_value <= throb_level_i;
				default:     pwm_value <= pulse_level_i;
			endcase
			led_o <= (pwm_count_i < pwm_value);
		end
	end

endmodule

//--- source/status_led_top.sv
`include "status_led_settings.svh"

module status_led_top
	import status_led_pkg::*;
(
	input  logic                            CLK_IN,
	input  logic                            RESET_IN,
	// APB slave
	input  logic                            psel_i,
	input  logic                            penable_i,
	input  logic                            pwrite_i,
	input  apb_addr_t                       paddr_i,
	input  apb_data_t                       pwdata_i,
	output apb_data_t                       prdata_o,
	output logic                            pready_o,
	output logic                            pslverr_o,
	// Per-device activity strobes and LEDs
	input  logic [`STATUS_NUM_DEVICES-1:0] activity_i,
	output logic [`STATUS_NUM_DEVICES-1:0] led_o
);

	// Software masks
	logic [`STATUS_NUM_DEVICES-1:0] error_mask;
	logic [`STATUS_NUM_DEVICES-1:0] connected_mask;
	// Recent activity per device
	logic [`STATUS_NUM_DEVICES-1:0] activity_status;

	// Shared animation timing
	logic [`STATUS_PWM_BITS-1:0] pwm_count;
	logic [`STATUS_PWM_BITS-1:0] pulse_level;
	logic [`STATUS_PWM_BITS-1:0] blink_level;
	logic [`STATUS_PWM_BITS-1:0] throb_level;
	logic                        period_end;

	genvar i;

	////////////////////////////////////////////////////////////////////////
	// Control and timing
	////////////////////////////////////////////////////////////////////////

	status_apb_regs regs0
	(
		.CLK_IN            (CLK_IN),
		.RESET_IN          (RESET_IN),
		.psel_i            (psel_i),
		.penable_i         (penable_i),
		.pwrite_i          (pwrite_i),
		.paddr_i           (paddr_i),
		.pwdata_i          (pwdata_i),
		.activity_status_i (activity_status),
		.period_end_i      (period_end),
		.prdata_o          (prdata_o),
		.pready_o          (pready_o),
		.pslverr_o         (pslverr_o),
		.error_mask_o      (error_mask),
		.connected_mask_o  (connected_mask)
	);

	led_animation_timer timer0
	(
		.CLK_IN        (CLK_IN),
		.RESET_IN      (RESET_IN),
		.pwm_count_o   (pwm_count),
		.pulse_level_o (pulse_level),
		.blink_level_o (blink_level),
		.throb_level_o (throb_level),
		.period_end_o  (period_end)
	);

	activity_timeout timeout0
	(
		.CLK_IN            (CLK_IN),
		.RESET_IN          (RESET_IN),
		.activity_i        (activity_i),
		.activity_status_o (activity_status)
	);

	// One PWM channel per LED
	generate
		for (i = 0; i < `STATUS_NUM_DEVICES; i++)
		begin : led_channel
			led_pwm_channel channel0
			(
				.CLK_IN        (CLK_IN),
				.RESET_IN      (RESET_IN),
				.error_i       (error_mask[i]),
				.connected_i   (connected_mask[i]),
				.active_i      (activity_status[i]),
				.pwm_count_i   (pwm_count),
				.pulse_level_i (pulse_level),
				.blink_level_i (blink_level),
				.throb_level_i (throb_level),
				.led_o         (led_o[i])
			);
		end
	endgenerate

endmodule

//--- verification/status_led_tb.sv
`include "status_led_settings.svh"

module status_led_tb
	import status_led_pkg::*;
();

	localparam int NUM_DEV    = `STATUS_NUM_DEVICES;
	localparam int PERIOD     = 1 << `STATUS_PERIOD_BITS;
	localparam int WINDOW     = 1 << `STATUS_PWM_BITS;
	localparam int PWM_FULL   = WINDOW - 1;
	localparam int CLK_PERIOD = 8;
	localparam int STROBE_GAP = 100;
	localparam int SETTLE     = 64;
	localparam int DUTY_TOL   = 32;
	// One full blink cycle, lit for its upper half
	localparam int BLINK_SPAN = 2 << `STATUS_BLINK_BIT;
	localparam int NUM_BLOCKS = PERIOD / BLINK_SPAN;
	// Twelve animation periods plus room for the APB traffic
	localparam int WATCHDOG_CYCLES = 12 * PERIOD + 2000;

	logic               CLK_IN;
	logic               RESET_IN;
	logic               psel_i;
	logic               penable_i;
	logic               pwrite_i;
	apb_addr_t          paddr_i;
	apb_data_t          pwdata_i;
	apb_data_t          prdata_o;
	logic               pready_o;
	logic               pslverr_o;
	logic [NUM_DEV-1:0] activity_i;
	logic [NUM_DEV-1:0] led_o;

	int     value_errors = 0;
	int     other_errors = 0;
	int     check_count  = 0;
	int     cycle_count  = 0;
	int     lit_count [NUM_DEV];
	// Lit cycles per blink cycle of the measured period
	int     block_lit [NUM_DEV][NUM_BLOCKS];
	logic [31:0] lfsr_state = 32'hcffa_2e12;

	status_led_top dut0
	(
		.CLK_IN     (CLK_IN),
		.RESET_IN   (RESET_IN),
		.psel_i     (psel_i),
		.penable_i  (penable_i),
		.pwrite_i   (pwrite_i),
		.paddr_i    (paddr_i),
		.pwdata_i   (pwdata_i),
		.prdata_o   (prdata_o),
		.pready_o   (pready_o),
		.pslverr_o  (pslverr_o),
		.activity_i (activity_i),
		.led_o      (led_o)
	);

	initial
	begin
		CLK_IN = 1'b0;
		forever #(CLK_PERIOD / 2) CLK_IN = ~CLK_IN;
	end

	always @(posedge CLK_IN)
		cycle_count <= cycle_count + 1;

	////////////////////////////////////////////////////////////////////////////
	// Protocol and reset properties
	////////////////////////////////////////////////////////////////////////////

	// Slave has no wait states
	assert property (@(posedge CLK_IN) pready_o)
	else
	begin
		other_errors++;
		$display("pready_o went low although the slave never stalls");
	end

	assert property (@(posedge CLK_IN) RESET_IN |-> (led_o == '0 && !pslverr_o))
	else
	begin
		other_errors++;
		$display("An LED or the slave error was active while reset was held");
	end

	// Slave error only inside an access phase
	assert property (@(posedge CLK_IN) disable iff (RESET_IN)
		pslverr_o |-> (psel_i && penable_i))
	else
	begin
		other_errors++;
		$display("pslverr_o was high outside an APB access phase");
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks, random bits and reference model
	////////////////////////////////////////////////////////////////////////////

	task automatic check_equal(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		assert (expected === actual)
		else
		begin
			value_errors++;
			$display("error %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	task automatic check_near(input string name, input int expected, input int actual,
		input int tol);
		check_count++;
		assert (actual >= expected - tol && actual <= expected + tol)
		else
		begin
			value_errors++;
			$display("error %s expected %0d (+/- %0d) actual %0d", name, expected, tol, actual);
		end
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int k = 0; k < n; k++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	function automatic led_mode_t expected_mode(input logic err, input logic conn,
		input logic act);
		if (err)
			return MODE_ERROR;
		if (conn)
			return act ? MODE_ACTIVE : MODE_IDLE;
		return MODE_OFF;
	endfunction

	// Throb rises over the first half and falls over the second in PWM windows
	function automatic int throb_duty();
		int total;
		int pos;
		int ramp;
		total = 0;
		for (int w = 0; w < PERIOD / WINDOW; w++)
		begin
			pos  = w * WINDOW;
			ramp = (pos >> (`STATUS_PERIOD_BITS - 1 - `STATUS_PWM_BITS)) % WINDOW;
			total += (pos >= PERIOD / 2) ? PWM_FULL - ramp : ramp;
		end
		return total;
	endfunction

	// Lit cycles over one whole period
	function automatic int mode_duty(input led_mode_t mode);
		case (mode)
			MODE_ERROR:  return (PERIOD - `STATUS_PULSE_CYCLES) * PWM_FULL / WINDOW;
			MODE_ACTIVE: return (PERIOD / 2) * PWM_FULL / WINDOW;
			MODE_IDLE:   return throb_duty();
			default:     return `STATUS_PULSE_CYCLES * PWM_FULL / WINDOW;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////////////////////////////////////////

	// Setup then access with the response sampled mid access phase
	task automatic apb_transfer(input logic write, input apb_addr_t addr, input apb_data_t wdata,
		input logic exp_err, output apb_data_t rdata);
		@(posedge CLK_IN);
		psel_i    <= 1'b1;
		penable_i <= 1'b0;
		pwrite_i  <= write;
		paddr_i   <= addr;
		pwdata_i  <= wdata;
		@(posedge CLK_IN);
		penable_i <= 1'b1;
		@(negedge CLK_IN);
		rdata = prdata_o;
		check_equal($sformatf("slave error at offset %0h", addr), 32'(exp_err), 32'(pslverr_o));
		@(posedge CLK_IN);
		psel_i    <= 1'b0;
		penable_i <= 1'b0;
	endtask

	task automatic apb_write(input apb_addr_t addr, input apb_data_t data, input logic exp_err);
		apb_data_t unused;
		apb_transfer(1'b1, addr, data, exp_err, unused);
	endtask

	task automatic apb_read(input apb_addr_t addr, input logic exp_err, output apb_data_t data);
		apb_transfer(1'b0, addr, '0, exp_err, data);
	endtask

	task automatic strobe_device(input int dev);
		logic [NUM_DEV-1:0] one_hot;
		one_hot      = '0;
		one_hot[dev] = 1'b1;
		@(posedge CLK_IN);
		activity_i <= one_hot;
		@(posedge CLK_IN);
		activity_i <= '0;
	endtask

	// Strobes the chosen devices every STROBE_GAP cycles and counts lit cycles if asked
	task automatic run_cycles(input int cycles, input logic [NUM_DEV-1:0] strobe_mask,
		input logic measure);
		for (int c = 0; c < cycles; c++)
		begin
			@(posedge CLK_IN);
			activity_i <= (c % STROBE_GAP == 0) ? strobe_mask : '0;
			@(negedge CLK_IN);
			for (int j = 0; j < NUM_DEV; j++)
				if (measure && led_o[j])
				begin
					lit_count[j]++;
					block_lit[j][c / BLINK_SPAN]++;
				end
		end
		@(posedge CLK_IN);
		activity_i <= '0;
	endtask

	task automatic measure_duties(input string name, input logic [NUM_DEV-1:0] err,
		input logic [NUM_DEV-1:0] conn, input logic [NUM_DEV-1:0] strobe_mask);
		led_mode_t mode;
		apb_write(REG_ERROR, 32'(err), 1'b0);
		apb_write(REG_CONNECTED, 32'(conn), 1'b0);
		run_cycles(SETTLE, strobe_mask, 1'b0);
		for (int j = 0; j < NUM_DEV; j++)
		begin
			lit_count[j] = 0;
			for (int b = 0; b < NUM_BLOCKS; b++)
				block_lit[j][b] = 0;
		end
		run_cycles(PERIOD, strobe_mask, 1'b1);
		for (int j = 0; j < NUM_DEV; j++)
		begin
			mode = expected_mode(err[j], conn[j], strobe_mask[j]);
			check_near($sformatf("%s led %0d %s", name, j, mode.name()), mode_duty(mode),
				lit_count[j], DUTY_TOL);
			// Blink lights half of every blink cycle whatever its phase
			if (mode == MODE_ACTIVE)
				for (int b = 0; b < NUM_BLOCKS; b++)
					check_near($sformatf("%s led %0d blink block %0d", name, j, b),
						(BLINK_SPAN / 2) * PWM_FULL / WINDOW, block_lit[j][b], DUTY_TOL);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		apb_data_t   d;
		apb_data_t   p1;
		apb_data_t   p2;
		logic [31:0] r;
		logic [31:0] err_kept;
		logic [31:0] conn_kept;
		int          c1;
		int          dev;

		RESET_IN   = 1'b1;
		psel_i     = 1'b0;
		penable_i  = 1'b0;
		pwrite_i   = 1'b0;
		paddr_i    = '0;
		pwdata_i   = '0;
		activity_i = '0;
		repeat (3) @(posedge CLK_IN);
		RESET_IN <= 1'b0;

		// Everything reads zero straight out of reset
		@(negedge CLK_IN);
		check_equal("led after reset", '0, 32'(led_o));
		apb_read(REG_ERROR, 1'b0, d);
		check_equal("error mask after reset", '0, d);
		apb_read(REG_CONNECTED, 1'b0, d);
		check_equal("connected mask after reset", '0, d);
		apb_read(REG_ACTIVITY, 1'b0, d);
		check_equal("activity after reset", '0, d);
		apb_read(REG_PERIODS, 1'b0, p1);
		c1 = cycle_count;
		check_equal("period count after reset", '0, p1);

		// Random masks keep only the device bits
		random_bits(32, r);
		err_kept = 32'(r[NUM_DEV-1:0]);
		apb_write(REG_ERROR, r, 1'b0);
		random_bits(32, r);
		conn_kept = 32'(r[NUM_DEV-1:0]);
		apb_write(REG_CONNECTED, r, 1'b0);
		apb_read(REG_ERROR, 1'b0, d);
		check_equal("error mask readback", err_kept, d);
		apb_read(REG_CONNECTED, 1'b0, d);
		check_equal("connected mask readback", conn_kept, d);

		// Bad accesses flag an error and change nothing
		apb_write(4'hD, 32'hffff_ffff, 1'b1);
		apb_read(4'hD, 1'b1, d);
		apb_read(4'hF, 1'b1, d);
		apb_write(REG_ACTIVITY, 32'hffff_ffff, 1'b1);
		apb_write(REG_PERIODS, 32'hffff_ffff, 1'b1);
		apb_read(REG_ERROR, 1'b0, d);
		check_equal("error mask after bad writes", err_kept, d);
		apb_read(REG_CONNECTED, 1'b0, d);
		check_equal("connected mask after bad writes", conn_kept, d);

		// Activity rises at once, retriggers, then times out
		random_bits(2, r);
		dev = int'(r[1:0]);
		random_bits(4, r);
		repeat (r[3:0]) @(posedge CLK_IN);
		strobe_device(dev);
		apb_read(REG_ACTIVITY, 1'b0, d);
		check_equal("activity after strobe", 32'd1 << dev, d);
		random_bits(6, r);
		repeat (STROBE_GAP + int'(r[5:0])) @(posedge CLK_IN);
		strobe_device(dev);
		random_bits(6, r);
		repeat (STROBE_GAP + int'(r[5:0])) @(posedge CLK_IN);
		apb_read(REG_ACTIVITY, 1'b0, d);
		check_equal("activity after renewed strobe", 32'd1 << dev, d);
		repeat (`STATUS_ACT_TIMEOUT) @(posedge CLK_IN);
		apb_read(REG_ACTIVITY, 1'b0, d);
		check_equal("activity after timeout", '0, d);

		// Device 0 error, 1 active, 2 idle, 3 off
		measure_duties("duty by mode", 4'b0001, 4'b0110, 4'b0010);
		// Error overrides activity, disconnect overrides idle
		measure_duties("duty priority", 4'b0011, 4'b0010, 4'b0010);

		apb_read(REG_PERIODS, 1'b0, p2);
		check_near("period count", (cycle_count - c1) / PERIOD, int'(p2) - int'(p1), 1);

		$display("checks %0d, value errors %0d, other errors %0d", check_count, value_errors,
			other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout after %0d cycles, the test sequence did not finish", WATCHDOG_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- compile.f
+incdir+include
source/status_led_pkg.sv
source/status_apb_regs.sv
source/led_animation_timer.sv
source/activity_timeout.sv
source/led_pwm_channel.sv
source/status_led_top.sv
verification/status_led_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the status LED testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f compile.f --top-module status_led_tb \
	-o status_led_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/status_led_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

# Result comes from the log
if grep -q "Simulation FAILED" sim.log; then
	exit 1
fi
exit 0
